//--- hw/data_mem.sv
`timescale 1ns/100ps
`include "mem_stage_config.svh"
`default_nettype none

module data_mem (
  input wire logic clk_i,
  input wire logic arst_n_i,
  dmem_if.slave    dmem
);

  localparam int unsigned IDX_W = $clog2(`DMEM_WORDS);
  localparam int unsigned CNT_W = $clog2(`DMEM_LATENCY + 1);

  mem_stage_pkg::xlen_t      mem_q [`DMEM_WORDS];
  logic                      busy_q;   // waiting out the latency
  logic                      ready_q;
  logic [CNT_W-1:0]          cnt_q;    // cycles left until ready
  logic                      sample;
  logic [IDX_W-1:0]          idx_q;    // sampled request
  logic                      write_q;
  mem_stage_pkg::byte_mask_t mask_q;
  mem_stage_pkg::xlen_t      wdata_q;

  // take a new request only when idle, never during the ready cycle
  assign sample = dmem.req_valid & (|dmem.size) & ~busy_q & ~ready_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q  <= 1'b0;
      ready_q <= 1'b0;
      cnt_q   <= '0;
    end else begin
      ready_q <= 1'b0;                              // pulse
      if (sample) begin
        busy_q  <= (`DMEM_LATENCY > 1);
        ready_q <= (`DMEM_LATENCY == 1);
        cnt_q   <= CNT_W'(`DMEM_LATENCY - 1);
      end else if (busy_q) begin
        cnt_q <= cnt_q - 1'b1;
        if (cnt_q == CNT_W'(1)) begin
          busy_q  <= 1'b0;
          ready_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sample) begin
      idx_q   <= dmem.addr[IDX_W+2:3];
      write_q <= dmem.write;
      mask_q  <= dmem.mask;
      wdata_q <= dmem.wdata;
    end
    if (ready_q && write_q) begin                   // write lands with the ready pulse
      for (int b = 0; b < 8; b++) begin
        if (mask_q[b]) mem_q[idx_q][b*8 +: 8] <= wdata_q[b*8 +: 8];
      end
    end
  end

  assign dmem.ready = ready_q;
  assign dmem.rdata = mem_q[idx_q];                 // only looked at while ready

endmodule

`default_nettype wire

//--- hw/dmem_if.sv
`timescale 1ns/100ps
`default_nettype none

// memory stage <-> data memory, level request and one-cycle ready
interface dmem_if;

  logic                      req_valid; // held while access wanted
  mem_stage_pkg::maddr_t     addr;
  logic                      write;     // 1 store, 0 load
  mem_stage_pkg::byte_mask_t mask;      // lane aligned
  mem_stage_pkg::mem_size_t  size;
  mem_stage_pkg::xlen_t      wdata;     // lane aligned
  logic                      ready;     // single pulse
  mem_stage_pkg::xlen_t      rdata;     // whole doubleword

  modport master (
    output req_valid, addr, write, mask, size, wdata,
    input  ready, rdata
  );

  modport slave (
    input  req_valid, addr, write, mask, size, wdata,
    output ready, rdata
  );

endinterface

`default_nettype wire

//--- hw/ex_mem_reg.sv
`timescale 1ns/100ps
`default_nettype none

module ex_mem_reg (
  input  wire logic                    clk_i,
  input  wire logic                    arst_n_i,
  input  wire logic                    advance_i,   // no stall, no hold
  input  wire logic                    in_valid_i,
  input  wire mem_stage_pkg::xlen_t    in_pc_i,
  input  wire mem_stage_pkg::mem_op_e  in_op_i,
  input  wire mem_stage_pkg::xlen_t    in_addr_i,   // alu result
  input  wire mem_stage_pkg::xlen_t    in_wdata_i,  // rs2
  input  wire mem_stage_pkg::reg_idx_t in_rd_i,
  output logic                         ex_valid_o,
  output mem_stage_pkg::xlen_t         ex_pc_o,
  output mem_stage_pkg::mem_op_e       ex_op_o,
  output mem_stage_pkg::xlen_t         ex_addr_o,
  output mem_stage_pkg::xlen_t         ex_wdata_o,
  output mem_stage_pkg::reg_idx_t      ex_rd_o
);

  // control half, comes out of reset as a bubble
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_valid_o <= 1'b0;
      ex_op_o    <= mem_stage_pkg::MEMOP_NONE;
    end else if (advance_i) begin
      ex_valid_o <= in_valid_i;
      ex_op_o    <= in_valid_i ? in_op_i : mem_stage_pkg::MEMOP_NONE; // bubble never accesses
    end
  end

  // payload, loaded on advance only
  always_ff @(posedge clk_i) begin
    if (advance_i) begin
      ex_pc_o    <= in_pc_i;
      ex_addr_o  <= in_addr_i;
      ex_wdata_o <= in_wdata_i;
      ex_rd_o    <= in_rd_i;
    end
  end

endmodule

`default_nettype wire

//--- hw/mem_access.sv
`timescale 1ns/100ps
`include "mem_stage_config.svh"
`default_nettype none

module mem_access (
  input  wire mem_stage_pkg::mem_op_e ex_op_i,
  input  wire mem_stage_pkg::xlen_t   ex_addr_i,    // alu result = address
  input  wire mem_stage_pkg::xlen_t   ex_wdata_i,   // rs2 store data
  input  wire logic                   buff_valid_i, // access already done, held in buffer
  input  wire mem_stage_pkg::xlen_t   buff_data_i,
  dmem_if.master                      dmem,
  output mem_stage_pkg::xlen_t        mem_data_o,   // result toward wb
  output logic                        stall_o,
  output logic                        done_o
);

  logic is_none, is_b, is_h, is_w, is_d;
  logic is_signed, is_load, is_store;
  logic req;
  logic [2:0] lane;                       // low address bits
  mem_stage_pkg::maddr_t     addr;
  mem_stage_pkg::byte_mask_t mask_base;   // unshifted mask
  mem_stage_pkg::xlen_t      wdata_base;  // store data cut to width
  mem_stage_pkg::xlen_t      rdata_lane;  // returned word moved down to lane 0
  mem_stage_pkg::xlen_t      load_ext;

  // opcode decode
  assign is_none = (ex_op_i == mem_stage_pkg::MEMOP_NONE);
  assign is_b = (ex_op_i == mem_stage_pkg::LB) | (ex_op_i == mem_stage_pkg::LBU)
              | (ex_op_i == mem_stage_pkg::SB);
  assign is_h = (ex_op_i == mem_stage_pkg::LH) | (ex_op_i == mem_stage_pkg::LHU)
              | (ex_op_i == mem_stage_pkg::SH);
  assign is_w = (ex_op_i == mem_stage_pkg::LW) | (ex_op_i == mem_stage_pkg::LWU)
              | (ex_op_i == mem_stage_pkg::SW);
  assign is_d = (ex_op_i == mem_stage_pkg::LD) | (ex_op_i == mem_stage_pkg::SD);

  assign is_signed = (ex_op_i == mem_stage_pkg::LB) | (ex_op_i == mem_stage_pkg::LH)
                   | (ex_op_i == mem_stage_pkg::LW) | (ex_op_i == mem_stage_pkg::LD);
  assign is_load = is_signed | (ex_op_i == mem_stage_pkg::LBU)
                 | (ex_op_i == mem_stage_pkg::LHU) | (ex_op_i == mem_stage_pkg::LWU);
  assign is_store = (ex_op_i == mem_stage_pkg::SB) | (ex_op_i == mem_stage_pkg::SH)
                  | (ex_op_i == mem_stage_pkg::SW) | (ex_op_i == mem_stage_pkg::SD);

  assign addr = is_none ? `MEM_RESET_ADDR : ex_addr_i[31:0];
  assign lane = addr[2:0];

  // width masks, parallel and-or select
  assign mask_base = ({8{is_b}} & 8'b0000_0001)
                   | ({8{is_h}} & 8'b0000_0011)
                   | ({8{is_w}} & 8'b0000_1111)
                   | ({8{is_d}} & 8'b1111_1111);

  assign wdata_base = ({64{is_b}} & {56'b0, ex_wdata_i[7:0]})
                    | ({64{is_h}} & {48'b0, ex_wdata_i[15:0]})
                    | ({64{is_w}} & {32'b0, ex_wdata_i[31:0]})
                    | ({64{is_d}} & ex_wdata_i);

  assign rdata_lane = dmem.rdata >> {lane, 3'b000};

  // sign bit only kept for the signed loads
  assign load_ext = ({64{is_b}} & {{56{is_signed & rdata_lane[7]}}, rdata_lane[7:0]})
                  | ({64{is_h}} & {{48{is_signed & rdata_lane[15]}}, rdata_lane[15:0]})
                  | ({64{is_w}} & {{32{is_signed & rdata_lane[31]}}, rdata_lane[31:0]})
                  | ({64{is_d}} & rdata_lane);

  // no request in the ready cycle or once buffered, so one access per instr
  assign req = (is_load | is_store) & ~dmem.ready & ~buff_valid_i;

  assign dmem.req_valid = req;
  assign dmem.addr      = addr;
  assign dmem.write     = is_store & req;
  assign dmem.mask      = mask_base << lane;              // lane aligned
  assign dmem.size      = {is_d, is_w, is_h, is_b};       // zero for alu ops
  assign dmem.wdata     = wdata_base << {lane, 3'b000};

  always_comb begin
    if (buff_valid_i)
      mem_data_o = buff_data_i;                           // result from earlier ready
    else if (is_load)
      mem_data_o = dmem.ready ? load_ext : '0;
    else if (is_none)
      mem_data_o = ex_addr_i;                             // pass alu value
    else
      mem_data_o = '0;                                    // stores write nothing back
  end

  assign stall_o = req;
  assign done_o  = dmem.ready;

endmodule

`default_nettype wire

//--- hw/mem_stage_config.svh
`ifndef MEM_STAGE_CONFIG_SVH
`define MEM_STAGE_CONFIG_SVH

`default_nettype none

// data memory depth in doublewords, index from addr[10:3]
`define DMEM_WORDS 256

// cycles from sampled request to ready pulse
`define DMEM_LATENCY 3

`define MEM_RESET_ADDR 32'h0000_0000  // addr driven when no access

`default_nettype wire

`endif

//--- hw/mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

  typedef logic [63:0] xlen_t;      // rv64 data word or address
  typedef logic [31:0] maddr_t;     // dmem byte address
  typedef logic [4:0]  reg_idx_t;   // rd index
  typedef logic [7:0]  byte_mask_t; // one bit per byte lane
  typedef logic [3:0]  mem_size_t;  // one-hot {8,4,2,1} bytes, zero = no access

  // memory opcode carried down from decode
  typedef enum logic [3:0] {
    MEMOP_NONE = 4'd0,  // alu op or bubble
    LB         = 4'd1,
    LBU        = 4'd2,
    LH         = 4'd3,
    LHU        = 4'd4,
    LW         = 4'd5,
    LWU        = 4'd6,
    LD         = 4'd7,
    SB         = 4'd8,
    SH         = 4'd9,
    SW         = 4'd10,
    SD         = 4'd11
  } mem_op_e;

endpackage

`default_nettype wire

//--- hw/mem_subsys_top.sv
`timescale 1ns/100ps
`default_nettype none

module mem_subsys_top (
  input  wire logic                    clk_i,
  input  wire logic                    arst_n_i,
  input  wire logic                    in_valid_i,
  input  wire mem_stage_pkg::xlen_t    in_pc_i,
  input  wire mem_stage_pkg::mem_op_e  in_op_i,
  input  wire mem_stage_pkg::xlen_t    in_addr_i,
  input  wire mem_stage_pkg::xlen_t    in_wdata_i,
  input  wire mem_stage_pkg::reg_idx_t in_rd_i,
  input  wire logic                    hold_i,     // outside pipeline hold
  output logic                         stall_o,
  output logic                         wb_valid_o,
  output mem_stage_pkg::xlen_t         wb_pc_o,
  output mem_stage_pkg::reg_idx_t      wb_rd_o,
  output mem_stage_pkg::xlen_t         wb_data_o
);

  dmem_if dmem0 ();

  logic                    advance;
  logic                    stall;
  logic                    done;
  logic                    ex_valid;
  mem_stage_pkg::xlen_t    ex_pc;
  mem_stage_pkg::mem_op_e  ex_op;
  mem_stage_pkg::xlen_t    ex_addr;
  mem_stage_pkg::xlen_t    ex_wdata;
  mem_stage_pkg::reg_idx_t ex_rd;
  mem_stage_pkg::xlen_t    mem_data;
  logic                    buff_valid;
  mem_stage_pkg::xlen_t    buff_data;

  assign advance = ~stall & ~hold_i;

  ex_mem_reg u_ex_mem (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .advance_i  (advance),
    .in_valid_i (in_valid_i),
    .in_pc_i    (in_pc_i),
    .in_op_i    (in_op_i),
    .in_addr_i  (in_addr_i),
    .in_wdata_i (in_wdata_i),
    .in_rd_i    (in_rd_i),
    .ex_valid_o (ex_valid),
    .ex_pc_o    (ex_pc),
    .ex_op_o    (ex_op),
    .ex_addr_o  (ex_addr),
    .ex_wdata_o (ex_wdata),
    .ex_rd_o    (ex_rd)
  );

  mem_access u_mem_access (
    .ex_op_i      (ex_op),
    .ex_addr_i    (ex_addr),
    .ex_wdata_i   (ex_wdata),
    .buff_valid_i (buff_valid),
    .buff_data_i  (buff_data),
    .dmem         (dmem0.master),
    .mem_data_o   (mem_data),
    .stall_o      (stall),
    .done_o       (done)
  );

  data_mem u_data_mem (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .dmem     (dmem0.slave)
  );

  mem_wb_reg u_mem_wb (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .hold_i       (hold_i),
    .stall_i      (stall),
    .done_i       (done),
    .ex_valid_i   (ex_valid),
    .ex_pc_i      (ex_pc),
    .ex_rd_i      (ex_rd),
    .mem_data_i   (mem_data),
    .buff_valid_o (buff_valid),
    .buff_data_o  (buff_data),
    .wb_valid_o   (wb_valid_o),
    .wb_pc_o      (wb_pc_o),
    .wb_rd_o      (wb_rd_o),
    .wb_data_o    (wb_data_o)
  );

  assign stall_o = stall;

endmodule

`default_nettype wire

//--- hw/mem_wb_reg.sv
`timescale 1ns/100ps
`default_nettype none

module mem_wb_reg (
  input  wire logic                    clk_i,
  input  wire logic                    arst_n_i,
  input  wire logic                    hold_i,
  input  wire logic                    stall_i,
  input  wire logic                    done_i,     // ready pulse from the stage
  input  wire logic                    ex_valid_i,
  input  wire mem_stage_pkg::xlen_t    ex_pc_i,
  input  wire mem_stage_pkg::reg_idx_t ex_rd_i,
  input  wire mem_stage_pkg::xlen_t    mem_data_i,
  output logic                         buff_valid_o,
  output mem_stage_pkg::xlen_t         buff_data_o,
  output logic                         wb_valid_o,
  output mem_stage_pkg::xlen_t         wb_pc_o,
  output mem_stage_pkg::reg_idx_t      wb_rd_o,
  output mem_stage_pkg::xlen_t         wb_data_o
);

  logic advance;

  assign advance = ~stall_i & ~hold_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_valid_o   <= 1'b0;
      buff_valid_o <= 1'b0;
    end else begin
      if (advance)
        wb_valid_o <= ex_valid_i;
      else if (!hold_i)
        wb_valid_o <= 1'b0;                       // stalled, insert bubble
      // access buffer, keeps a finished access while held
      if (advance)
        buff_valid_o <= 1'b0;
      else if (done_i && hold_i)
        buff_valid_o <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      wb_pc_o   <= ex_pc_i;
      wb_rd_o   <= ex_rd_i;
      wb_data_o <= mem_data_i;
    end
    if (done_i && hold_i) buff_data_o <= mem_data_i;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+hw
hw/mem_stage_pkg.sv
hw/dmem_if.sv
hw/ex_mem_reg.sv
hw/mem_access.sv
hw/data_mem.sv
hw/mem_wb_reg.sv
hw/mem_subsys_top.sv
testbench/mem_subsys_properties.sv
testbench/tb_mem_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds tb_mem_subsys with Verilator, runs it, then searches the log for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_mem_subsys -f project.f \
  -o sim_tb_mem_subsys > build.log 2>&1 \
  && ./obj_dir/sim_tb_mem_subsys > sim.log 2>&1 \
  || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -qx "NO ERRORS" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

//--- testbench/mem_subsys_properties.sv
`timescale 1ns/100ps
`include "mem_stage_config.svh"
`default_nettype none

module mem_subsys_properties (
  input wire logic clk_i,
  input wire logic arst_n_i,
  input wire logic hold_i,
  input wire logic stall_i,     // top-level stall_o
  input wire logic wb_valid_i   // top-level wb_valid_o
);

  logic [3:0] stall_run_q;  // consecutive stall cycles so far
  logic       stall_d_q;
  logic [3:0] req_cnt_q;    // stall rises for the instr now in the stage
  int         fail_cnt = 0; // failed assertions so far

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      stall_run_q <= '0;
      stall_d_q   <= 1'b0;
      req_cnt_q   <= '0;
    end else begin
      stall_d_q   <= stall_i;
      stall_run_q <= stall_i ? stall_run_q + 4'd1 : 4'd0;
      if (!stall_i && !hold_i)
        req_cnt_q <= '0;                        // instr leaves at this edge
      else if (stall_i && !stall_d_q)
        req_cnt_q <= req_cnt_q + 4'd1;          // new request level
    end
  end

  // quiet while held in reset and on the first edge after it
  reset_quiet: assert property (@(posedge clk_i) !arst_n_i |-> !stall_i && !wb_valid_i)
    else begin
      $error("stall or wb valid high during reset");
      fail_cnt++;
    end
  reset_exit: assert property (@(posedge clk_i) $rose(arst_n_i) |-> !stall_i && !wb_valid_i)
    else begin
      $error("stall or wb valid high right after reset");
      fail_cnt++;
    end

  // one access stalls for exactly the memory latency
  stall_len: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $fell(stall_i) |-> stall_run_q == 4'(`DMEM_LATENCY))
    else begin
      $error("stall length differs from the memory latency");
      fail_cnt++;
    end
  stall_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    stall_i |-> stall_run_q < 4'(`DMEM_LATENCY))
    else begin
      $error("stall held longer than the memory latency");
      fail_cnt++;
    end

  one_request: assert property (@(posedge clk_i) disable iff (!arst_n_i) req_cnt_q <= 4'd1)
    else begin
      $error("second request issued for the same instruction");
      fail_cnt++;
    end

endmodule

`default_nettype wire

//--- testbench/tb_mem_subsys.sv
`timescale 1ns/100ps
`include "mem_stage_config.svh"
`default_nettype none

module tb_mem_subsys;

  localparam int RESET_CYCLES = 5;
  localparam int MEM_BYTES    = `DMEM_WORDS * 8;
  localparam int NUM_OPS      = 24 + 9 + 8 + 5;     // ops over all four tests
  localparam int MAX_CYCLES   = NUM_OPS * (`DMEM_LATENCY + 4) + RESET_CYCLES;

  logic                    clk;
  logic                    arst_n;
  logic                    in_valid;
  mem_stage_pkg::xlen_t    in_pc;
  mem_stage_pkg::mem_op_e  in_op;
  mem_stage_pkg::xlen_t    in_addr;
  mem_stage_pkg::xlen_t    in_wdata;
  mem_stage_pkg::reg_idx_t in_rd;
  logic                    hold;
  logic                    stall;
  logic                    wb_valid;
  mem_stage_pkg::xlen_t    wb_pc;
  mem_stage_pkg::reg_idx_t wb_rd;
  mem_stage_pkg::xlen_t    wb_data;

  logic [7:0]  ref_mem [MEM_BYTES];   // byte model, follows issued stores
  logic [31:0] rand_state;
  int          cycles;
  int          checks;
  int          errors;
  int          test_checks;           // counts at the start of a test
  int          test_errors;
  int          op_count;

  mem_subsys_top dut0 (
    .clk_i      (clk),
    .arst_n_i   (arst_n),
    .in_valid_i (in_valid),
    .in_pc_i    (in_pc),
    .in_op_i    (in_op),
    .in_addr_i  (in_addr),
    .in_wdata_i (in_wdata),
    .in_rd_i    (in_rd),
    .hold_i     (hold),
    .stall_o    (stall),
    .wb_valid_o (wb_valid),
    .wb_pc_o    (wb_pc),
    .wb_rd_o    (wb_rd),
    .wb_data_o  (wb_data)
  );

  bind mem_subsys_top mem_subsys_properties props0 (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .hold_i     (hold_i),
    .stall_i    (stall_o),
    .wb_valid_i (wb_valid_o)
  );

  always #50 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("timeout: DUT gave no result within %0d cycles", MAX_CYCLES);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;  // lcg step
    return rand_state;
  endfunction

  function automatic int op_bytes(input mem_stage_pkg::mem_op_e op);
    case (op)
      mem_stage_pkg::LB, mem_stage_pkg::LBU, mem_stage_pkg::SB: return 1;
      mem_stage_pkg::LH, mem_stage_pkg::LHU, mem_stage_pkg::SH: return 2;
      mem_stage_pkg::LW, mem_stage_pkg::LWU, mem_stage_pkg::SW: return 4;
      default: return 8;
    endcase
  endfunction

  // little endian gather, then fill the upper bits
  function automatic logic [63:0] expected_load(input mem_stage_pkg::mem_op_e op, input int a);
    int          n;
    logic [63:0] val;
    logic        neg;
    n   = op_bytes(op);
    val = '0;
    for (int i = 0; i < n; i++) val[i*8 +: 8] = ref_mem[a + i];
    neg = val[n*8-1] && (op == mem_stage_pkg::LB || op == mem_stage_pkg::LH
                         || op == mem_stage_pkg::LW);   // signed forms only
    for (int i = n * 8; i < 64; i++) val[i] = neg;
    return val;
  endfunction

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  // one instruction through the stage, called and returning on a falling edge
  task automatic run_op(input mem_stage_pkg::mem_op_e op, input logic [63:0] addr,
                        input logic [63:0] data, input logic with_hold);
    logic [63:0] exp_data;
    logic [63:0] pc;
    logic [31:0] r;
    logic [4:0]  rd;
    r        = next_rand();
    rd       = r[4:0];
    pc       = 64'h8000_0000 + 64'(op_count * 4);
    op_count = op_count + 1;
    case (op)
      mem_stage_pkg::MEMOP_NONE: exp_data = addr;     // alu value passes through
      mem_stage_pkg::SB, mem_stage_pkg::SH, mem_stage_pkg::SW, mem_stage_pkg::SD: begin
        exp_data = '0;                                // stores write back zero
        for (int i = 0; i < op_bytes(op); i++) ref_mem[int'(addr[10:0]) + i] = data[i*8 +: 8];
      end
      default: exp_data = expected_load(op, int'(addr[10:0]));
    endcase
    in_valid = 1'b1;
    in_op    = op;
    in_addr  = addr;
    in_wdata = data;
    in_rd    = rd;
    in_pc    = pc;
    @(posedge clk);                                   // stage is empty, so taken here
    @(negedge clk);
    in_valid = 1'b0;
    in_op    = mem_stage_pkg::MEMOP_NONE;
    if (with_hold) begin
      hold = 1'b1;
      while (stall) @(negedge clk);                   // up to the ready cycle
      @(negedge clk);
      @(negedge clk);
      hold = 1'b0;
    end
    while (!wb_valid) begin
      if (op == mem_stage_pkg::MEMOP_NONE)
        compare("stall_o", 64'(stall), 64'd0);        // alu ops never stall
      @(negedge clk);
    end
    compare("wb_data_o", wb_data, exp_data);
    compare("wb_rd_o", 64'(wb_rd), 64'(rd));
    compare("wb_pc_o", wb_pc, pc);
  endtask

  // random aligned lane, store then one or two loads from it
  task automatic store_then_load(input mem_stage_pkg::mem_op_e st,
                                 input mem_stage_pkg::mem_op_e ld_a,
                                 input mem_stage_pkg::mem_op_e ld_b,
                                 input logic set_msb, input logic with_hold);
    int          n;
    int          a;
    logic [63:0] d;
    logic [31:0] r;
    n = op_bytes(st);
    r = next_rand();
    a = int'(r % MEM_BYTES) & ~(n - 1);
    d = {next_rand(), next_rand()};
    if (set_msb) d[n*8-1] = 1'b1;                     // forces a negative load
    run_op(st, 64'(a), d, with_hold);
    run_op(ld_a, 64'(a), '0, with_hold);
    if (ld_b != mem_stage_pkg::MEMOP_NONE) run_op(ld_b, 64'(a), '0, with_hold);
  endtask

  task automatic mark_test_start();
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic print_test_result(input string name);
    $display("test %-12s %0d checks, %0d errors", name, checks - test_checks,
             errors - test_errors);
  endtask

  initial begin
    rand_state  = 32'd80351;
    clk         = 1'b0;
    arst_n      = 1'b0;
    in_valid    = 1'b0;
    in_pc       = '0;
    in_op       = mem_stage_pkg::MEMOP_NONE;
    in_addr     = '0;
    in_wdata    = '0;
    in_rd       = '0;
    hold        = 1'b0;
    cycles      = 0;
    checks      = 0;
    errors      = 0;
    test_checks = 0;
    test_errors = 0;
    op_count    = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    mark_test_start();
    for (int r = 0; r < 3; r++) begin
      store_then_load(mem_stage_pkg::SB, (r == 1) ? mem_stage_pkg::LBU : mem_stage_pkg::LB,
                      mem_stage_pkg::MEMOP_NONE, 1'b0, 1'b0);
      store_then_load(mem_stage_pkg::SH, (r == 1) ? mem_stage_pkg::LHU : mem_stage_pkg::LH,
                      mem_stage_pkg::MEMOP_NONE, 1'b0, 1'b0);
      store_then_load(mem_stage_pkg::SW, (r == 1) ? mem_stage_pkg::LWU : mem_stage_pkg::LW,
                      mem_stage_pkg::MEMOP_NONE, 1'b0, 1'b0);
      store_then_load(mem_stage_pkg::SD, mem_stage_pkg::LD,
                      mem_stage_pkg::MEMOP_NONE, 1'b0, 1'b0);
    end
    print_test_result("store_load");

    mark_test_start();
    store_then_load(mem_stage_pkg::SB, mem_stage_pkg::LB, mem_stage_pkg::LBU, 1'b1, 1'b0);
    store_then_load(mem_stage_pkg::SH, mem_stage_pkg::LH, mem_stage_pkg::LHU, 1'b1, 1'b0);
    store_then_load(mem_stage_pkg::SW, mem_stage_pkg::LW, mem_stage_pkg::LWU, 1'b1, 1'b0);
    print_test_result("extend");

    mark_test_start();
    for (int i = 0; i < 8; i++)
      run_op(mem_stage_pkg::MEMOP_NONE, {next_rand(), next_rand()}, '0, 1'b0);
    print_test_result("alu_pass");

    mark_test_start();
    store_then_load(mem_stage_pkg::SD, mem_stage_pkg::LD, mem_stage_pkg::MEMOP_NONE,
                    1'b0, 1'b1);
    store_then_load(mem_stage_pkg::SH, mem_stage_pkg::LH, mem_stage_pkg::LHU, 1'b1, 1'b1);
    print_test_result("hold");

    errors = errors + dut0.props0.fail_cnt;            // bound assertion failures
    $display("total %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
